/* common/tcdm_pkg.sv */
// Sizes are fixed for four initiators and four banks; address bits above bit 9 are ignored
package tcdm_pkg;

  // Cluster sizes
  localparam int unsigned NumIn  = 4;  // Initiators
  localparam int unsigned NumOut = 4;  // Banks

  localparam int unsigned IniIdxWidth  = 2;
  localparam int unsigned BankIdxWidth = 2;

  // Address and data fields
  localparam int unsigned AddrWidth     = 16;  // Byte address seen by an initiator
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = 4;
  localparam int unsigned ByteOffWidth  = 2;
  localparam int unsigned BankAddrWidth = 6;   // 64 words per bank

  // Spill register enables
  localparam bit SpillReq  = 1'b1;  // Initiator request side
  localparam bit SpillResp = 1'b1;  // Bank response side

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [BeWidth-1:0]       be_t;
  typedef logic [IniIdxWidth-1:0]   ini_idx_t;
  typedef logic [BankIdxWidth-1:0]  bank_idx_t;
  typedef logic [BankAddrWidth-1:0] bank_addr_t;

  // Request as issued by an initiator
  typedef struct packed {
    addr_t addr;
    logic  wen;   // 1 for write
    data_t wdata;
    be_t   be;
  } tcdm_req_t;

  // Request as seen by a bank
  typedef struct packed {
    ini_idx_t   ini;   // Filled in by the crossbar
    bank_addr_t addr;
    logic       wen;
    data_t      wdata;
    be_t        be;
  } bank_req_t;

  typedef struct packed {
    ini_idx_t ini;  // Routes the response back
    data_t    rdata;
  } bank_resp_t;

  typedef enum logic [1:0] {IDLE, BUSY, RESP} bank_state_e;

endpackage

/* logic/spill_register.sv */
// Two-entry elastic buffer; with Bypass set it is a plain wire and adds no cycle
`timescale 1ns/100ps

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;  // Combinational path through
    assign data_o  = data_i;
  end else begin : gen_spill
    logic a_full_q, b_full_q;  // Slot A takes input, slot B catches a stalled A
    T     a_data_q, b_data_q;
    logic a_fill, a_drain, b_fill, b_drain;

    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;  // A leaves to output or to B
    assign b_fill  = a_drain & ~ready_i;    // Output stalled, park A in B
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill | a_drain) a_full_q <= a_fill;
        if (b_fill | b_drain) b_full_q <= b_fill;
      end
    end

    // Payload slots
    always_ff @(posedge clk_i) begin
      if (a_fill) a_data_q <= data_i;
      if (b_fill) b_data_q <= a_data_q;
    end

    assign ready_o = ~a_full_q | ~b_full_q;  // Free while one slot is empty
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;  // B is always older
  end

endmodule

/* interconnect/rr_arbiter.sv */
// Round-robin arbiter; requests must stay high until granted, grant holds while ready_i is low
`timescale 1ns/100ps

module rr_arbiter #(
  parameter int unsigned NumReq   = 4,
  parameter int unsigned IdxWidth = $clog2(NumReq)
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [NumReq-1:0]   req_i,
  output logic [NumReq-1:0]   gnt_o,   // One-hot
  output logic [IdxWidth-1:0] idx_o,
  input  logic                ready_i  // Granted output accepts
);

  logic [IdxWidth-1:0] ptr_q;   // Highest priority requester
  logic                lock_q;  // Grant stalled, hold it
  logic [NumReq-1:0]   gnt_q;
  logic [IdxWidth-1:0] idx_q;
  logic [NumReq-1:0]   gnt_arb;
  logic [IdxWidth-1:0] idx_arb;

  // Search upward from the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    logic        found;
    gnt_arb = '0;
    idx_arb = '0;
    found   = 1'b0;
    for (int unsigned off = 0; off < NumReq; off++) begin
      cand = (int'(ptr_q) + off) % NumReq;
      if (!found && req_i[cand]) begin
        found         = 1'b1;
        gnt_arb[cand] = 1'b1;
        idx_arb       = IdxWidth'(cand);
      end
    end
  end

  assign gnt_o = lock_q ? gnt_q : gnt_arb;
  assign idx_o = lock_q ? idx_q : idx_arb;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
      gnt_q  <= '0;
      idx_q  <= '0;
    end else if (|gnt_o) begin
      if (ready_i) begin  // Transfer, rotate past the winner
        ptr_q  <= (idx_o == IdxWidth'(NumReq - 1)) ? '0 : idx_o + 1'b1;
        lock_q <= 1'b0;
      end else begin
        lock_q <= 1'b1;
        gnt_q  <= gnt_o;
        idx_q  <= idx_o;
      end
    end
  end

endmodule

/* interconnect/full_duplex_xbar.sv */
// Combinational full crossbar; one arbiter per bank for requests and per initiator for responses
`timescale 1ns/100ps

module full_duplex_xbar import tcdm_pkg::*; (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Initiator side
  input  logic       [NumIn-1:0]  ini_valid_i,
  output logic       [NumIn-1:0]  ini_ready_o,
  input  bank_idx_t  [NumIn-1:0]  ini_bank_i,       // Target bank per initiator
  input  bank_req_t  [NumIn-1:0]  ini_req_i,        // ini field ignored here
  output logic       [NumIn-1:0]  ini_resp_valid_o,
  input  logic       [NumIn-1:0]  ini_resp_ready_i,
  output data_t      [NumIn-1:0]  ini_rdata_o,
  // Bank side
  output logic       [NumOut-1:0] bank_valid_o,
  input  logic       [NumOut-1:0] bank_ready_i,
  output bank_req_t  [NumOut-1:0] bank_req_o,
  input  logic       [NumOut-1:0] bank_resp_valid_i,
  output logic       [NumOut-1:0] bank_resp_ready_o,
  input  bank_resp_t [NumOut-1:0] bank_resp_i
);

  logic     [NumOut-1:0][NumIn-1:0] req_hit;   // Per bank, initiators addressing it
  logic     [NumOut-1:0][NumIn-1:0] req_gnt;
  ini_idx_t [NumOut-1:0]            req_idx;
  logic     [NumIn-1:0][NumOut-1:0] resp_hit;  // Per initiator, banks answering it
  logic     [NumIn-1:0][NumOut-1:0] resp_gnt;
  bank_idx_t [NumIn-1:0]            resp_idx;

  // Request side, one arbiter per bank
  for (genvar b = 0; b < NumOut; b++) begin : gen_req
    for (genvar i = 0; i < NumIn; i++) begin : gen_hit
      assign req_hit[b][i] = ini_valid_i[i] && (ini_bank_i[i] == bank_idx_t'(b));
    end

    rr_arbiter #(
      .NumReq  (NumIn),
      .IdxWidth(IniIdxWidth)
    ) i_req_arb (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (req_hit[b]),
      .gnt_o   (req_gnt[b]),
      .idx_o   (req_idx[b]),
      .ready_i (bank_ready_i[b])
    );

    assign bank_valid_o[b] = |req_hit[b];
    // Winner payload, tagged with its initiator index
    assign bank_req_o[b] = '{ini:   req_idx[b],
                             addr:  ini_req_i[req_idx[b]].addr,
                             wen:   ini_req_i[req_idx[b]].wen,
                             wdata: ini_req_i[req_idx[b]].wdata,
                             be:    ini_req_i[req_idx[b]].be};
  end

  // Ready only to the winner of the addressed bank
  for (genvar i = 0; i < NumIn; i++) begin : gen_ini_ready
    assign ini_ready_o[i] = req_gnt[ini_bank_i[i]][i] & bank_ready_i[ini_bank_i[i]];
  end

  // Response side, one arbiter per initiator
  for (genvar i = 0; i < NumIn; i++) begin : gen_resp
    for (genvar b = 0; b < NumOut; b++) begin : gen_hit
      assign resp_hit[i][b] = bank_resp_valid_i[b] && (bank_resp_i[b].ini == ini_idx_t'(i));
    end

    rr_arbiter #(
      .NumReq  (NumOut),
      .IdxWidth(BankIdxWidth)
    ) i_resp_arb (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (resp_hit[i]),
      .gnt_o   (resp_gnt[i]),
      .idx_o   (resp_idx[i]),
      .ready_i (ini_resp_ready_i[i])
    );

    assign ini_resp_valid_o[i] = |resp_hit[i];
    assign ini_rdata_o[i]      = bank_resp_i[resp_idx[i]].rdata;
  end

  for (genvar b = 0; b < NumOut; b++) begin : gen_bank_ready
    // Granted by the initiator it names, and that initiator takes it
    assign bank_resp_ready_o[b] = resp_gnt[bank_resp_i[b].ini][b]
                                & ini_resp_ready_i[bank_resp_i[b].ini];
  end

endmodule

/* interconnect/vl_interconnect.sv */
// Crossbar with spill registers; bank index is addr[3:2], word offset addr[9:4], rest unused
`timescale 1ns/100ps

module vl_interconnect import tcdm_pkg::*; (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Initiator side
  input  tcdm_req_t  [NumIn-1:0]  req_i,
  input  logic       [NumIn-1:0]  req_valid_i,
  output logic       [NumIn-1:0]  req_ready_o,
  output logic       [NumIn-1:0]  resp_valid_o,
  input  logic       [NumIn-1:0]  resp_ready_i,
  output data_t      [NumIn-1:0]  resp_rdata_o,
  // Bank side
  output logic       [NumOut-1:0] bank_valid_o,
  input  logic       [NumOut-1:0] bank_ready_i,
  output bank_req_t  [NumOut-1:0] bank_req_o,
  input  logic       [NumOut-1:0] bank_resp_valid_i,
  output logic       [NumOut-1:0] bank_resp_ready_o,
  input  bank_resp_t [NumOut-1:0] bank_resp_i
);

  tcdm_req_t  [NumIn-1:0]  ini_req;  // After request spill
  logic       [NumIn-1:0]  ini_valid;
  logic       [NumIn-1:0]  ini_ready;
  bank_idx_t  [NumIn-1:0]  ini_bank;
  bank_req_t  [NumIn-1:0]  ini_breq;
  bank_resp_t [NumOut-1:0] tgt_resp;  // After response spill
  logic       [NumOut-1:0] tgt_valid;
  logic       [NumOut-1:0] tgt_ready;

  for (genvar i = 0; i < NumIn; i++) begin : gen_req_spill
    spill_register #(
      .T     (tcdm_req_t),
      .Bypass(!SpillReq)
    ) i_req_spill (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .valid_i (req_valid_i[i]),
      .ready_o (req_ready_o[i]),
      .data_i  (req_i[i]),
      .valid_o (ini_valid[i]),
      .ready_i (ini_ready[i]),
      .data_o  (ini_req[i])
    );

    // Bank select sits just above the byte offset
    assign ini_bank[i] = ini_req[i].addr[ByteOffWidth +: BankIdxWidth];
    assign ini_breq[i] = '{ini:   '0,  // Set by the crossbar
                           addr:  ini_req[i].addr[ByteOffWidth + BankIdxWidth +: BankAddrWidth],
                           wen:   ini_req[i].wen,
                           wdata: ini_req[i].wdata,
                           be:    ini_req[i].be};
  end

  for (genvar b = 0; b < NumOut; b++) begin : gen_resp_spill
    spill_register #(
      .T     (bank_resp_t),
      .Bypass(!SpillResp)
    ) i_resp_spill (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .valid_i (bank_resp_valid_i[b]),
      .ready_o (bank_resp_ready_o[b]),
      .data_i  (bank_resp_i[b]),
      .valid_o (tgt_valid[b]),
      .ready_i (tgt_ready[b]),
      .data_o  (tgt_resp[b])
    );
  end

  full_duplex_xbar i_xbar (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .ini_valid_i      (ini_valid),
    .ini_ready_o      (ini_ready),
    .ini_bank_i       (ini_bank),
    .ini_req_i        (ini_breq),
    .ini_resp_valid_o (resp_valid_o),
    .ini_resp_ready_i (resp_ready_i),
    .ini_rdata_o      (resp_rdata_o),
    .bank_valid_o     (bank_valid_o),
    .bank_ready_i     (bank_ready_i),
    .bank_req_o       (bank_req_o),
    .bank_resp_valid_i(tgt_valid),
    .bank_resp_ready_o(tgt_ready),
    .bank_resp_i      (tgt_resp)
  );

endmodule

/* logic/tcdm_bank.sv */
// Single-request bank with 64 words; memory is not cleared by reset, reads of unwritten words are X
`timescale 1ns/100ps

module tcdm_bank import tcdm_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  bank_req_t  req_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output bank_resp_t resp_o
);

  data_t       mem_q [2**BankAddrWidth];
  bank_state_e state_q;
  logic [3:0]  lfsr_q;    // Service time source
  logic        extra_q;   // One more BUSY cycle left
  bank_resp_t  resp_q;
  logic        accept;

  assign req_ready_o  = (state_q == IDLE);  // One request at a time
  assign accept       = req_valid_i & req_ready_o;
  assign resp_valid_o = (state_q == RESP);
  assign resp_o       = resp_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      lfsr_q  <= 4'b1001;  // Any nonzero seed
      extra_q <= 1'b0;
    end else begin
      unique case (state_q)
        IDLE: if (accept) begin
          state_q <= BUSY;
          extra_q <= lfsr_q[0];  // Low bit picks 1 or 2 cycles
          lfsr_q  <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};  // x^4 + x^3 + 1
        end
        BUSY: begin
          if (extra_q) extra_q <= 1'b0;
          else         state_q <= RESP;
        end
        RESP: if (resp_ready_i) state_q <= IDLE;  // Held until taken
        default: state_q <= IDLE;
      endcase
    end
  end

  // Storage and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.ini <= req_i.ini;  // Route back to the requester
      if (req_i.wen) begin
        resp_q.rdata <= '0;  // Writes answer with zero
        for (int unsigned k = 0; k < BeWidth; k++) begin
          if (req_i.be[k]) mem_q[req_i.addr][8*k +: 8] <= req_i.wdata[8*k +: 8];
        end
      end else begin
        resp_q.rdata <= mem_q[req_i.addr];
      end
    end
  end

endmodule

/* logic/tcdm_cluster_top.sv */
// Four initiators, four banks; keep one request in flight per initiator for in-order responses
`timescale 1ns/100ps

module tcdm_cluster_top import tcdm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tcdm_req_t [NumIn-1:0] req_i,
  input  logic      [NumIn-1:0] req_valid_i,
  output logic      [NumIn-1:0] req_ready_o,
  output logic      [NumIn-1:0] resp_valid_o,
  input  logic      [NumIn-1:0] resp_ready_i,
  output data_t     [NumIn-1:0] resp_rdata_o
);

  // Interconnect to bank links
  logic       [NumOut-1:0] bank_valid;
  logic       [NumOut-1:0] bank_ready;
  bank_req_t  [NumOut-1:0] bank_req;
  logic       [NumOut-1:0] bank_resp_valid;
  logic       [NumOut-1:0] bank_resp_ready;
  bank_resp_t [NumOut-1:0] bank_resp;

  vl_interconnect i_vl_interconnect (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_i            (req_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .resp_rdata_o     (resp_rdata_o),
    .bank_valid_o     (bank_valid),
    .bank_ready_i     (bank_ready),
    .bank_req_o       (bank_req),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ready_o(bank_resp_ready),
    .bank_resp_i      (bank_resp)
  );

  for (genvar b = 0; b < NumOut; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (bank_valid[b]),
      .req_ready_o (bank_ready[b]),
      .req_i       (bank_req[b]),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b]),
      .resp_o      (bank_resp[b])
    );
  end

endmodule

/* verif/tcdm_checker.sv */
// Bound into tcdm_cluster_top; stability checks are off while reset is asserted
`timescale 1ns/100ps

module tcdm_checker import tcdm_pkg::*; (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input tcdm_req_t [NumIn-1:0] req_i,
  input logic      [NumIn-1:0] req_valid_i,
  input logic      [NumIn-1:0] req_ready_i,
  input logic      [NumIn-1:0] resp_valid_i,
  input logic      [NumIn-1:0] resp_ready_i,
  input data_t     [NumIn-1:0] resp_rdata_i
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  for (genvar i = 0; i < NumIn; i++) begin : gen_ini
    // Stalled request keeps valid and payload
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_i[i] && !req_ready_i[i] |=> req_valid_i[i] && $stable(req_i[i]))
    else begin
      $error("Request on initiator %0d dropped or changed while stalled", i);
      fail_cnt++;
    end

    // Stalled response keeps valid and data
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_i[i] && !resp_ready_i[i] |=> resp_valid_i[i] && $stable(resp_rdata_i[i]))
    else begin
      $error("Response on initiator %0d dropped or changed while stalled", i);
      fail_cnt++;
    end
  end

  // No response in reset nor on the first edge after it
  assert property (@(posedge clk_i) (!arst_n_i || $rose(arst_n_i)) |-> resp_valid_i == '0)
  else begin
    $error("Response valid high in or right after reset");
    fail_cnt++;
  end

endmodule

bind tcdm_cluster_top tcdm_checker i_tcdm_checker (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_i       (req_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .resp_valid_i(resp_valid_o),
  .resp_ready_i(resp_ready_i),
  .resp_rdata_i(resp_rdata_o)
);

/* verif/tcdm_monitor.sv */
// Needs one request in flight per initiator; unwritten words in the model are X
`timescale 1ns/100ps

module tcdm_monitor import tcdm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tcdm_req_t [NumIn-1:0] req_i,
  input  logic      [NumIn-1:0] req_valid_i,
  input  logic      [NumIn-1:0] req_ready_i,   // DUT req_ready_o
  input  logic      [NumIn-1:0] resp_valid_i,  // DUT resp_valid_o
  input  logic      [NumIn-1:0] resp_ready_i,
  input  data_t     [NumIn-1:0] resp_rdata_i,
  output int                    data_err_o,
  output int                    proto_err_o
);

  data_t mem_model [NumOut][2**BankAddrWidth];  // Bank, word
  data_t exp_q [NumIn][$];                      // Expected rdata per initiator
  string row_name = "reset";                    // Current row, set by the testbench
  int    data_errs = 0;
  int    proto_errs = 0;

  assign data_err_o  = data_errs;
  assign proto_err_o = proto_errs;

  // Word after a byte-enable write
  function automatic data_t merge_bytes(data_t old_word, data_t wdata, be_t be);
    data_t res;
    res = old_word;
    for (int k = 0; k < BeWidth; k++) begin
      if (be[k]) res[8*k +: 8] = wdata[8*k +: 8];
    end
    return res;
  endfunction

  always @(posedge clk_i) begin
    bank_idx_t  bank;
    bank_addr_t word;
    data_t      exp;
    if (!arst_n_i) begin
      if (resp_valid_i != '0) begin
        $display("Response valid raised during reset: %b", resp_valid_i);
        proto_errs++;
      end
    end else begin
      for (int i = 0; i < NumIn; i++) begin
        if (resp_valid_i[i] && resp_ready_i[i]) begin
          if (exp_q[i].size() == 0) begin
            $display("Initiator %0d got a response with nothing outstanding in %s", i, row_name);
            proto_errs++;
          end else begin
            exp = exp_q[i].pop_front();
            if (resp_rdata_i[i] !== exp) begin
              $display("ERROR %s: initiator %0d expected %h, actual %h",
                       row_name, i, exp, resp_rdata_i[i]);
              data_errs++;
            end
          end
        end
        // Model follows the order of acceptance
        if (req_valid_i[i] && req_ready_i[i]) begin
          bank = req_i[i].addr[ByteOffWidth +: BankIdxWidth];
          word = req_i[i].addr[ByteOffWidth + BankIdxWidth +: BankAddrWidth];
          if (req_i[i].wen) begin
            mem_model[bank][word] = merge_bytes(mem_model[bank][word], req_i[i].wdata,
                                                req_i[i].be);
            exp_q[i].push_back('0);  // Writes answer zero
          end else begin
            exp_q[i].push_back(mem_model[bank][word]);
          end
        end
      end
    end
  end

endmodule

/* verif/tb_tcdm_cluster.sv */
// One request per initiator per row keeps responses in order; rows never read unwritten words
`timescale 1ns/100ps

module tb_tcdm_cluster import tcdm_pkg::*; ();

  localparam int unsigned NumRows     = 10;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned MaxCycles   = 40 * NumRows + ResetCycles;
  localparam int unsigned Seed        = 32'h64b1_a4e1;

  typedef struct packed {
    logic      en;   // Initiator takes part in the row
    tcdm_req_t req;
  } slot_t;

  logic                  clk;
  logic                  arst_n;
  tcdm_req_t [NumIn-1:0] req;
  logic      [NumIn-1:0] req_valid;
  logic      [NumIn-1:0] req_ready;
  logic      [NumIn-1:0] resp_valid;
  logic      [NumIn-1:0] resp_ready;
  data_t     [NumIn-1:0] resp_rdata;
  int                    data_errs;
  int                    proto_errs;
  string                 row_name  [NumRows];
  int unsigned           row_stall [NumRows];  // Percent of cycles with resp_ready low
  slot_t     [NumIn-1:0] row_slot  [NumRows];
  int unsigned           stall_pct;
  int unsigned           cycle_cnt;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  tcdm_cluster_top i_tcdm_cluster_top (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata)
  );

  tcdm_monitor i_tcdm_monitor (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_i (req_ready),
    .resp_valid_i(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_i(resp_rdata),
    .data_err_o  (data_errs),
    .proto_err_o (proto_errs)
  );

  // Byte address of a word in a bank
  function automatic addr_t word_addr(int unsigned bank, int unsigned word);
    return addr_t'({word[BankAddrWidth-1:0], bank[BankIdxWidth-1:0], 2'b00});
  endfunction

  task automatic name_row(int r, string name, int unsigned stall);
    row_name[r]  = name;
    row_stall[r] = stall;
    row_slot[r]  = '0;
  endtask

  task automatic put_request(int r, int i, logic wen, addr_t addr, data_t wdata, be_t be);
    row_slot[r][i].en  = 1'b1;
    row_slot[r][i].req = '{addr: addr, wen: wen, wdata: wdata, be: be};
  endtask

  task automatic load_table();
    name_row(0, "write_all_banks", 0);
    name_row(1, "read_rotated", 0);
    name_row(2, "byte_enable_write", 0);
    name_row(3, "byte_enable_read", 0);
    name_row(4, "conflict_write", 0);
    name_row(5, "conflict_read", 0);
    name_row(6, "parallel_mixed", 0);
    name_row(7, "stall_write", 50);
    name_row(8, "stall_read", 60);
    name_row(9, "stall_conflict_read", 50);
    for (int i = 0; i < NumIn; i++) begin
      put_request(0, i, 1'b1, word_addr(i, 3), 32'h1234_5678 ^ (32'h1111_1111 * i), 4'hF);
      put_request(1, i, 1'b0, word_addr((i + 1) % NumIn, 3), '0, 4'hF);
      put_request(2, i, 1'b1, word_addr(i, 3), 32'hDEAD_BEEF, 4'b0011 << i);  // Partial
      put_request(3, i, 1'b0, word_addr(i, 3), '0, 4'hF);
      put_request(4, i, 1'b1, word_addr(2, 10 + i), 32'hC0DE_0000 + i, 4'hF);  // All to bank 2
      put_request(5, i, 1'b0, word_addr(2, 13 - i), '0, 4'hF);
      if (i % 2 == 0) put_request(6, i, 1'b1, word_addr(i, 20), 32'h5A5A_0000 + i, 4'hF);
      else            put_request(6, i, 1'b0, word_addr(i, 3), '0, 4'hF);
      put_request(7, i, 1'b1, word_addr((i + 2) % NumIn, 7), 32'h0BAD_F00D + (i << 8), 4'hF);
      put_request(8, i, 1'b0, word_addr((i + 1) % NumIn, 7), '0, 4'hF);
      put_request(9, i, 1'b0, word_addr(2, 10 + i), '0, 4'hF);
    end
  endtask

  // Hold each request until accepted, return once every response is back
  task automatic run_row(int r);
    int unsigned      need;
    int unsigned      got;
    logic [NumIn-1:0] taken;
    i_tcdm_monitor.row_name = row_name[r];
    stall_pct = row_stall[r];
    need = 0;
    got  = 0;
    for (int i = 0; i < NumIn; i++) begin
      req[i]       = row_slot[r][i].req;
      req_valid[i] = row_slot[r][i].en;
      if (row_slot[r][i].en) need++;
    end
    while (got < need) begin
      @(posedge clk);
      taken = req_valid & req_ready;
      for (int i = 0; i < NumIn; i++) begin
        if (resp_valid[i] && resp_ready[i]) got++;
      end
      #1;
      req_valid = req_valid & ~taken;
    end
  endtask

  task automatic report_and_finish(input bit timed_out);
    int unsigned assert_errs;
    assert_errs = i_tcdm_cluster_top.i_tcdm_checker.fail_cnt;
    $display("Errors: %0d data, %0d protocol, %0d assertion, %0d timeout",
             data_errs, proto_errs, assert_errs, timed_out);
    if (!timed_out && data_errs == 0 && proto_errs == 0 && assert_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  // Response back-pressure, one draw per initiator and cycle
  initial begin
    void'($urandom(Seed));
    resp_ready = '1;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < NumIn; i++) resp_ready[i] = ($urandom % 100) >= stall_pct;
    end
  end

  initial begin
    arst_n    = 1'b0;
    req       = '0;
    req_valid = '0;
    stall_pct = 0;
    load_table();
    repeat (ResetCycles) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int r = 0; r < NumRows; r++) run_row(r);
    repeat (4) @(posedge clk);  // Room for a stray extra response
    report_and_finish(1'b0);
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, requests or responses still outstanding", MaxCycles);
    report_and_finish(1'b1);
  end

endmodule

/* tcdm_cluster_top.f */
common/tcdm_pkg.sv
logic/spill_register.sv
interconnect/rr_arbiter.sv
interconnect/full_duplex_xbar.sv
interconnect/vl_interconnect.sv
logic/tcdm_bank.sv
logic/tcdm_cluster_top.sv
verif/tcdm_checker.sv
verif/tcdm_monitor.sv
verif/tb_tcdm_cluster.sv

/* Makefile */
TOP  := tb_tcdm_cluster
SRCS := $(shell grep -v '^+' tcdm_cluster_top.f)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tcdm_cluster_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f tcdm_cluster_top.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tcdm_cluster_top -f tcdm_cluster_top.f

clean:
	rm -rf obj_dir sim.log
